// ==== common/adpcm_consts.svh ====
// **********************************************************
// Sizes shared by the ADPCM-A fetch and decode blocks.
// The ring length and the slot count must stay equal.
// **********************************************************
`ifndef ADPCM_CONSTS_SVH
`define ADPCM_CONSTS_SVH

// Number of channels, which is also the number of ring stages.
`define ADPCM_SLOTS 6

// Byte address width of the external sample ROM.
`define ADPCM_ROM_AW 20

// Width of a start or end block number.
`define ADPCM_BLK_W 12

// Nibble address bits below one block.
`define ADPCM_BLK_SHIFT 9

// Width of a decoded sample.
`define ADPCM_SMP_W 16

`endif

// ==== common/adpcm_pkg.sv ====
// **********************************************************
// Types and ADPCM-A tables shared by the playback blocks.
// Field widths come from the constants header.
// **********************************************************
`include "adpcm_consts.svh"

package adpcm_pkg;

    typedef enum logic [1:0] {
        OP_START,                                   // Sets the start block.
        OP_END,                                     // Sets the end block.
        OP_KEYON,                                   // Starts playback.
        OP_KEYOFF                                   // Stops playback.
    } reg_op_e;

    typedef enum logic [1:0] {
        HOST_IDLE,                                  // No host read pending.
        HOST_WAIT,                                  // Read latched and waiting for a free ROM.
        HOST_DATA                                   // ROM byte returns in this cycle.
    } host_st_e;

    typedef struct packed {
        logic [`ADPCM_BLK_W-1:0] addr_in;           // Block number for start or end.
        logic                    up_start;          // Load the start block.
        logic                    up_end;            // Load the end block.
        logic                    aon;               // Key-on.
        logic                    aoff;              // Key-off.
    } cnt_ctl_t;

    typedef struct packed {
        logic [`ADPCM_ROM_AW-1:0] addr;             // ROM byte address.
        logic                     sel;              // Zero picks the high nibble.
        logic [2:0]               slot;             // Channel of this fetch.
        logic                     first;            // First fetch after key-on.
    } rom_req_t;

    typedef struct packed {
        logic                           valid;      // One-cycle sample strobe.
        logic [2:0]                     slot;       // Channel of the sample.
        logic signed [`ADPCM_SMP_W-1:0] value;      // Decoded output.
    } sample_t;

    // Standard ADPCM-A step sizes.
    localparam logic [10:0] step_table [49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66,
        73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253,
        279, 307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876,
        963, 1060, 1166, 1282, 1411, 1552
    };

    // Step index change, indexed by nibble magnitude.
    localparam logic signed [4:0] index_adj [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd5, 5'sd7, 5'sd9
    };

endpackage

// ==== src/adpcm_regs.sv ====
// **********************************************************
// Holds one host write until the ring shows its channel.
// wr_chan must be below the slot count, or the write never leaves.
// **********************************************************
`timescale 1ns/1ps
`include "adpcm_consts.svh"

module adpcm_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  logic                     wr,
    input  adpcm_pkg::reg_op_e       wr_op,
    input  logic [2:0]               wr_chan,
    input  logic [`ADPCM_BLK_W-1:0]  wr_data,
    input  logic [2:0]               cur_slot,
    output logic                     wr_busy,
    output adpcm_pkg::cnt_ctl_t      ctl
);
    import adpcm_pkg::*;

    reg_op_e                 op_q;                  // Pending opcode.
    logic [2:0]              chan_q;                // Pending channel.
    logic [`ADPCM_BLK_W-1:0] data_q;                // Pending block number.
    logic                    release_w;

    // The write leaves in the cen cycle where its slot sits in stage 1.
    assign release_w = wr_busy && cen && (cur_slot == chan_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy <= 1'b0;
        end else if (release_w) begin
            wr_busy <= 1'b0;                        // Falls one cycle after release.
        end else if (wr) begin
            wr_busy <= 1'b1;                        // A write while busy is dropped.
        end
    end

    always_ff @(posedge clk) begin
        if (wr && !wr_busy) begin
            op_q   <= wr_op;
            chan_q <= wr_chan;
            data_q <= wr_data;
        end
    end

    // Exactly one control bit is set in the release cycle.
    always_comb begin
        ctl = '0;
        if (release_w) begin
            ctl.addr_in = data_q;
            case (op_q)
                OP_START: ctl.up_start = 1'b1;
                OP_END:   ctl.up_end   = 1'b1;
                OP_KEYON: ctl.aon      = 1'b1;
                default:  ctl.aoff     = 1'b1;
            endcase
        end
    end

endmodule

// ==== adpcm_cnt/adpcm_cnt.sv ====
// **********************************************************
// Six-stage ring of per-channel nibble addresses.
// Each slot fetches once per six cen cycles and stops at its end block.
// The nibble at the end block address itself is not fetched.
// **********************************************************
`timescale 1ns/1ps
`include "adpcm_consts.svh"

module adpcm_cnt (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  adpcm_pkg::cnt_ctl_t  ctl,
    output logic [2:0]           cur_slot,
    output adpcm_pkg::rom_req_t  req,
    output logic                 roe_n
);
    import adpcm_pkg::*;

    localparam int AW = `ADPCM_BLK_W + `ADPCM_BLK_SHIFT;  // Nibble address width.

    typedef struct packed {
        logic [AW-1:0]           addr;              // Nibble address.
        logic [`ADPCM_BLK_W-1:0] start;             // Start block.
        logic [`ADPCM_BLK_W-1:0] stop;              // End block.
        logic                    on;                // Channel is playing.
        logic                    first;             // Next fetch is the first one.
        logic [2:0]              slot;              // Channel tag.
    } stage_t;

    stage_t st [`ADPCM_SLOTS];                      // Entry 0 is stage 1.
    logic   clr2;                                   // Key-on seen in stage 1.
    logic   done5;                                  // Address reached the end block.
    logic   run5;

    assign cur_slot = st[0].slot;
    assign run5     = st[4].on && !done5;           // Stage 5 will fetch and count.

    // **********************************************************
    // Ring advance
    // **********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ADPCM_SLOTS; i++) begin
                st[i]      <= '0;
                st[i].slot <= 3'((`ADPCM_SLOTS - i) % `ADPCM_SLOTS);  // Slot 0 starts in stage 1.
            end
            clr2  <= 1'b0;
            done5 <= 1'b0;
            roe_n <= 1'b1;
        end else if (cen) begin
            // Stage 1 takes the register write.
            st[1]    <= st[0];
            st[1].on <= ctl.aoff ? 1'b0 : (ctl.aon | st[0].on);
            if (ctl.up_start) begin
                st[1].start <= ctl.addr_in;
            end
            if (ctl.up_end) begin
                st[1].stop <= ctl.addr_in;
            end
            clr2 <= ctl.aon && !st[0].on;           // Only a fresh key-on reloads.

            // Stage 3 loads the start address after a key-on.
            st[2] <= st[1];
            if (clr2) begin
                st[2].addr  <= {st[1].start, {`ADPCM_BLK_SHIFT{1'b0}}};
                st[2].first <= 1'b1;
            end

            st[3] <= st[2];

            // Stage 5 compares against the end block.
            st[4] <= st[3];
            done5 <= st[3].addr[AW-1:`ADPCM_BLK_SHIFT] == st[3].stop;

            // Stage 6 issues the fetch and steps the address.
            st[5] <= st[4];
            if (run5) begin
                st[5].addr  <= st[4].addr + 1'b1;
                st[5].first <= 1'b0;
            end
            roe_n <= !run5;

            st[0] <= st[5];                         // Close the ring.
        end
    end

    // The fetch uses the address before its increment.
    always_ff @(posedge clk) begin
        if (cen) begin
            req.addr  <= st[4].addr[AW-1:1];        // Two nibbles per byte.
            req.sel   <= st[4].addr[0];
            req.slot  <= st[4].slot;
            req.first <= st[4].first;
        end
    end

endmodule

// ==== src/rom_arbiter.sv ====
// **********************************************************
// Shares the sample ROM between counter fetches and host reads.
// Counter fetches always win, so a host read may wait.
// A host_rd while host_busy is high is dropped.
// **********************************************************
`timescale 1ns/1ps
`include "adpcm_consts.svh"

module rom_arbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  adpcm_pkg::rom_req_t      req,
    input  logic                     roe_n,
    input  logic                     host_rd,
    input  logic [`ADPCM_ROM_AW-1:0] host_addr,
    input  logic [7:0]               rom_data,
    output logic                     host_busy,
    output logic                     host_valid,
    output logic [7:0]               host_data,
    output logic                     rom_cs,
    output logic [`ADPCM_ROM_AW-1:0] rom_addr,
    output adpcm_pkg::rom_req_t      fetch,
    output logic                     fetch_valid
);
    import adpcm_pkg::*;

    host_st_e                 state;
    logic [`ADPCM_ROM_AW-1:0] host_addr_q;          // Latched host address.
    logic                     cnt_fetch;

    assign cnt_fetch = cen && !roe_n;               // The counter owns the ROM this cycle.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HOST_IDLE;
        end else begin
            case (state)
                HOST_IDLE: if (host_rd) state <= HOST_WAIT;
                HOST_WAIT: if (!cnt_fetch) state <= HOST_DATA;  // First free cycle.
                default:   state <= HOST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == HOST_IDLE && host_rd) begin
            host_addr_q <= host_addr;
        end
    end

    assign rom_cs     = cnt_fetch || (state == HOST_WAIT);
    assign rom_addr   = cnt_fetch ? req.addr : host_addr_q;
    assign host_busy  = state != HOST_IDLE;
    assign host_valid = state == HOST_DATA;         // ROM answers one cycle after access.
    assign host_data  = rom_data;

    // The tag lines up with the ROM byte one cycle later.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= cnt_fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_fetch) begin
            fetch <= req;
        end
    end

endmodule

// ==== src/adpcm_decode.sv ====
// **********************************************************
// ADPCM-A decoder with one accumulator and step index per slot.
// A sample leaves one cycle after its ROM byte arrives.
// **********************************************************
`timescale 1ns/1ps
`include "adpcm_consts.svh"

module adpcm_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  adpcm_pkg::rom_req_t  fetch,
    input  logic                 fetch_valid,
    input  logic [7:0]           rom_data,
    output adpcm_pkg::sample_t   sample
);
    import adpcm_pkg::*;

    localparam int SW = `ADPCM_SMP_W;

    logic signed [SW-1:0] acc [`ADPCM_SLOTS];       // Per-slot accumulator.
    logic [5:0]           idx [`ADPCM_SLOTS];       // Per-slot step index.

    logic [3:0]           nib;
    logic signed [SW-1:0] acc_cur;
    logic [5:0]           idx_cur;
    logic [10:0]          step;
    logic [14:0]          prod;
    logic signed [SW+1:0] sum;
    logic signed [SW-1:0] acc_nxt;
    logic signed [7:0]    idx_sum;
    logic [5:0]           idx_nxt;

    // **********************************************************
    // Nibble decode
    // **********************************************************
    always_comb begin
        nib     = fetch.sel ? rom_data[3:0] : rom_data[7:4];  // High nibble comes first.
        acc_cur = fetch.first ? '0 : acc[fetch.slot];         // Key-on starts from zero.
        idx_cur = fetch.first ? '0 : idx[fetch.slot];
        step    = step_table[idx_cur];
        prod    = {nib[2:0], 1'b1} * step;                    // (2 * magnitude + 1) * step.
        if (nib[3]) begin
            sum = acc_cur - $signed({6'd0, prod[14:3]});      // Sign bit subtracts.
        end else begin
            sum = acc_cur + $signed({6'd0, prod[14:3]});
        end

        // Saturate when the top bits disagree.
        if (sum[SW+1] && !(&sum[SW:SW-1])) begin
            acc_nxt = {1'b1, {(SW-1){1'b0}}};
        end else if (!sum[SW+1] && (|sum[SW:SW-1])) begin
            acc_nxt = {1'b0, {(SW-1){1'b1}}};
        end else begin
            acc_nxt = sum[SW-1:0];
        end

        idx_sum = $signed({2'b00, idx_cur}) + index_adj[nib[2:0]];
        if (idx_sum < 0) begin
            idx_nxt = 6'd0;
        end else if (idx_sum > 8'sd48) begin
            idx_nxt = 6'd48;                        // Last entry of the step table.
        end else begin
            idx_nxt = idx_sum[5:0];
        end
    end

    // **********************************************************
    // State and output registers
    // **********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ADPCM_SLOTS; i++) begin
                acc[i] <= '0;
                idx[i] <= '0;
            end
            sample <= '0;
        end else begin
            sample.valid <= fetch_valid;
            if (fetch_valid) begin
                acc[fetch.slot] <= acc_nxt;
                idx[fetch.slot] <= idx_nxt;
                sample.slot     <= fetch.slot;
                sample.value    <= acc_nxt;
            end
        end
    end

endmodule

// ==== src/adpcm_top.sv ====
// **********************************************************
// Six-channel ADPCM-A fetch and decode subsystem.
// The ROM is synchronous with data one cycle after rom_cs.
// **********************************************************
`timescale 1ns/1ps
`include "adpcm_consts.svh"

module adpcm_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cen,
    input  logic                     wr,
    input  adpcm_pkg::reg_op_e       wr_op,
    input  logic [2:0]               wr_chan,
    input  logic [`ADPCM_BLK_W-1:0]  wr_data,
    input  logic                     host_rd,
    input  logic [`ADPCM_ROM_AW-1:0] host_addr,
    input  logic [7:0]               rom_data,
    output logic                     wr_busy,
    output logic                     host_busy,
    output logic                     host_valid,
    output logic [7:0]               host_data,
    output logic                     rom_cs,
    output logic [`ADPCM_ROM_AW-1:0] rom_addr,
    output adpcm_pkg::sample_t       sample
);
    import adpcm_pkg::*;

    cnt_ctl_t   ctl;                                // Register release into stage 1.
    logic [2:0] cur_slot;
    rom_req_t   req;                                // Counter fetch request.
    logic       roe_n;
    rom_req_t   fetch;                              // Fetch tag aligned with rom_data.
    logic       fetch_valid;

    adpcm_regs u_regs (
        .clk, .rst_n, .cen, .wr, .wr_op, .wr_chan, .wr_data,
        .cur_slot, .wr_busy, .ctl
    );

    adpcm_cnt u_cnt (
        .clk, .rst_n, .cen, .ctl, .cur_slot, .req, .roe_n
    );

    rom_arbiter u_arb (
        .clk, .rst_n, .cen, .req, .roe_n, .host_rd, .host_addr, .rom_data,
        .host_busy, .host_valid, .host_data, .rom_cs, .rom_addr,
        .fetch, .fetch_valid
    );

    adpcm_decode u_dec (
        .clk, .rst_n, .fetch, .fetch_valid, .rom_data, .sample
    );

endmodule

// ==== tests/adpcm_asserts.sv ====
// **********************************************************
// Concurrent checks on the ROM arbiter and the address ring.
// Bound once into each block, with the inputs it lacks tied off.
// **********************************************************
`timescale 1ns/1ps
`include "adpcm_consts.svh"

module adpcm_asserts (
    input logic clk,
    input logic rst_n,
    input logic cen,
    input logic roe_n,
    input logic fetch_ok,                           // Stage 6 slot is on and below its end block.
    input logic host_busy,
    input logic host_valid
);

    // A counter fetch owns the ROM, so no host data can follow that cycle.
    counter_owns_rom: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && !roe_n) |=> !host_valid)
        else $error("host read served during a counter fetch");

    // The host data strobe always closes a busy period.
    valid_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        host_valid |-> (host_busy && $past(host_busy)))
        else $error("host_valid rose without a pending host read");

    // A slot that is off or past its end block never pulls the fetch line low.
    fetch_needs_on: assert property (@(posedge clk) disable iff (!rst_n)
        !roe_n |-> fetch_ok)
        else $error("roe_n low for a slot that is off or done");

endmodule

bind rom_arbiter adpcm_asserts arb_chk (
    .clk, .rst_n, .cen, .roe_n, .fetch_ok(1'b1), .host_busy, .host_valid
);

bind adpcm_cnt adpcm_asserts cnt_chk (
    .clk, .rst_n, .cen, .roe_n,
    .fetch_ok(st[5].on && (req.addr[`ADPCM_ROM_AW-1:`ADPCM_BLK_SHIFT-1] != st[5].stop)),
    .host_busy(1'b0), .host_valid(1'b0)
);

// ==== tests/adpcm_tb.sv ====
// **********************************************************
// Testbench for the ADPCM-A fetch and decode subsystem.
// Counter fetches are observed inside the DUT at adpcm_cnt.
// The ROM model answers one cycle after rom_cs, 1 MiB of random bytes.
// **********************************************************
`timescale 1ns/1ps
`include "adpcm_consts.svh"

module adpcm_tb;
    import adpcm_pkg::*;

    localparam int NROWS = 6;
    localparam int NIB   = 1 << `ADPCM_BLK_SHIFT;   // Nibbles per block.

    typedef struct packed {
        logic [2:0]               chan;
        logic [`ADPCM_BLK_W-1:0]  start;
        logic [`ADPCM_BLK_W-1:0]  stop;
        logic [15:0]              off_after;        // Cycles before key-off, zero for none.
        logic [`ADPCM_ROM_AW-1:0] haddr;            // Host read address.
    } row_t;

    typedef struct packed {
        int due;                                    // Cycle in which the sample must show.
        int slot;
        int value;
    } exp_t;

    row_t rows [NROWS] = '{
        '{3'd0, 12'h001, 12'h002, 16'd0,   20'h00123},
        '{3'd1, 12'h010, 12'h011, 16'd400, 20'h0abcd},
        '{3'd2, 12'h7ff, 12'h800, 16'd0,   20'hfffff},
        '{3'd3, 12'h123, 12'h125, 16'd0,   20'h40000},
        '{3'd4, 12'h0ff, 12'h100, 16'd250, 20'h00000},
        '{3'd5, 12'hffe, 12'hfff, 16'd0,   20'h80001}
    };

    // ADPCM-A step sizes for the reference decoder.
    int step_ref [49] = '{16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66,
        73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307, 337,
        371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166, 1282, 1411, 1552};

    logic                     clk;
    logic                     rst_n;
    logic                     cen;
    logic                     wr;
    reg_op_e                  wr_op;
    logic [2:0]               wr_chan;
    logic [`ADPCM_BLK_W-1:0]  wr_data;
    logic                     host_rd;
    logic [`ADPCM_ROM_AW-1:0] host_addr;
    logic [7:0]               rom_data;
    logic                     wr_busy;
    logic                     host_busy;
    logic                     host_valid;
    logic [7:0]               host_data;
    logic                     rom_cs;
    logic [`ADPCM_ROM_AW-1:0] rom_addr;
    sample_t                  sample;

    logic [7:0] rom [1 << `ADPCM_ROM_AW];           // External sample ROM.
    bit         m_on [`ADPCM_SLOTS];                // Reference model of each channel.
    int         m_start [`ADPCM_SLOTS];
    int         m_stop [`ADPCM_SLOTS];
    int         m_nib [`ADPCM_SLOTS];               // Next nibble address to fetch.
    int         m_cnt [`ADPCM_SLOTS];               // Fetches since the last key-on.
    int         m_acc [`ADPCM_SLOTS];
    int         m_idx [`ADPCM_SLOTS];
    exp_t       exp_q [$];                          // Samples still to come, oldest first.
    int         cyc = 0;
    int         cen_cnt = 0;
    int         err_val = 0;
    int         err_other = 0;

    adpcm_top DUT (
        .clk, .rst_n, .cen, .wr, .wr_op, .wr_chan, .wr_data, .host_rd, .host_addr,
        .rom_data, .wr_busy, .host_busy, .host_valid, .host_data, .rom_cs, .rom_addr,
        .sample
    );

    // **********************************************************
    // Clock, clock enable and ROM model
    // **********************************************************
    initial clk = 1'b0;
    always #50 clk = ~clk;                          // 100 ns period.

    always @(posedge clk) begin
        #5;
        cen_cnt = cen_cnt + 1;
        cen = (cen_cnt % 7) != 0;                   // Low one cycle in seven.
    end

    always @(posedge clk) begin
        if (rom_cs)
            rom_data <= rom[rom_addr];              // Synchronous read.
    end

    // **********************************************************
    // Reference model and reporting
    // **********************************************************
    task automatic report_mismatch(input string name, input int got, input int exp);
        err_val = err_val + 1;
        $display("FAIL time=%0t %s got %0d expected %0d", $time, name, got, exp);
    endtask

    task automatic report_error(input string msg);
        err_other = err_other + 1;
        $display("ERROR at time %0t: %s", $time, msg);
    endtask

    function automatic void ref_decode(input int s, input logic [3:0] nib);
        int mag;
        int diff;
        int adj;
        mag      = nib[2:0];
        diff     = ((2 * mag + 1) * step_ref[m_idx[s]]) / 8;
        m_acc[s] = nib[3] ? m_acc[s] - diff : m_acc[s] + diff;    // Bit 3 is the sign.
        m_acc[s] = (m_acc[s] > 32767) ? 32767 : (m_acc[s] < -32768) ? -32768 : m_acc[s];
        adj      = (mag < 4) ? -1 : (mag == 4) ? 2 : (mag == 5) ? 5 : (mag == 6) ? 7 : 9;
        m_idx[s] = m_idx[s] + adj;
        m_idx[s] = (m_idx[s] < 0) ? 0 : (m_idx[s] > 48) ? 48 : m_idx[s];
    endfunction

    task automatic record_fetch(input rom_req_t rq);
        int         s;
        logic [7:0] b;
        s = rq.slot;
        if (!m_on[s] || m_nib[s] >= m_stop[s] * NIB) begin
            report_error($sformatf("fetch for channel %0d while it is not playing", s));
        end else begin
            if ({rq.addr, rq.sel} != m_nib[s])
                report_mismatch("nibble address", {rq.addr, rq.sel}, m_nib[s]);
            if (rom_cs !== 1'b1)
                report_mismatch("rom_cs", rom_cs, 1);
            if (rom_addr != (m_nib[s] >> 1))
                report_mismatch("rom_addr", rom_addr, m_nib[s] >> 1);
            if (rq.first != (m_cnt[s] == 0))
                report_mismatch("req.first", rq.first, m_cnt[s] == 0);
            b = rom[m_nib[s] >> 1];
            ref_decode(s, m_nib[s][0] ? b[3:0] : b[7:4]);  // Even nibble is the high one.
            exp_q.push_back(exp_t'{cyc + 2, s, m_acc[s]});
            m_nib[s] = m_nib[s] + 1;
            m_cnt[s] = m_cnt[s] + 1;
        end
    endtask

    // Samples and fetches are both stable at the falling edge.
    always @(negedge clk) begin
        exp_t e;
        if (rst_n) begin
            cyc = cyc + 1;
            if (sample.valid) begin
                if (exp_q.size() == 0) begin
                    report_error($sformatf("sample on slot %0d without a fetch", sample.slot));
                end else begin
                    e = exp_q.pop_front();
                    if (cyc != e.due)
                        report_mismatch("sample cycle", cyc, e.due);
                    if (sample.slot != e.slot)
                        report_mismatch("sample.slot", sample.slot, e.slot);
                    if ($signed(sample.value) != e.value)
                        report_mismatch("sample.value", $signed(sample.value), e.value);
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
                e = exp_q.pop_front();
                report_error($sformatf("no sample for slot %0d two cycles after fetch", e.slot));
            end
            if (cen && !DUT.u_cnt.roe_n)
                record_fetch(DUT.u_cnt.req);
        end
    end

    // **********************************************************
    // Host-side stimulus
    // **********************************************************
    task automatic reg_write(input reg_op_e op, input int ch, input int data);
        int n;
        @(posedge clk);
        #5;
        wr      = 1'b1;
        wr_op   = op;
        wr_chan = 3'(ch);
        wr_data = 12'(data);
        @(posedge clk);
        #5;
        wr = 1'b0;
        n  = 0;
        do begin
            @(negedge clk);
            n = n + 1;
        end while (wr_busy && n < 30);              // Release comes within six cen cycles.
        if (wr_busy)
            report_error($sformatf("register write to channel %0d was never released", ch));
        case (op)
            OP_START: m_start[ch] = data;
            OP_END:   m_stop[ch] = data;
            OP_KEYON: begin
                if (!m_on[ch]) begin
                    m_on[ch]  = 1'b1;               // Fresh key-on restarts from the start block.
                    m_nib[ch] = m_start[ch] * NIB;
                    m_cnt[ch] = 0;
                    m_acc[ch] = 0;
                    m_idx[ch] = 0;
                end
            end
            default:  m_on[ch] = 1'b0;
        endcase
    endtask

    task automatic host_read(input logic [`ADPCM_ROM_AW-1:0] a);
        int n;
        @(posedge clk);
        #5;
        host_rd   = 1'b1;
        host_addr = a;
        @(posedge clk);
        #5;
        host_rd = 1'b0;
        n       = 0;
        do begin
            @(negedge clk);
            n = n + 1;
            if (host_busy !== 1'b1)
                report_mismatch("host_busy", host_busy, 1);   // Busy until the data strobe.
        end while (!host_valid && n < 50);
        if (!host_valid)
            report_error($sformatf("host read of address %h never returned", a));
        else if (host_data != rom[a])
            report_mismatch("host_data", host_data, rom[a]);
    endtask

    // **********************************************************
    // Test sequence
    // **********************************************************
    initial begin
        void'($urandom(32'hef631128));
        for (int i = 0; i < (1 << `ADPCM_ROM_AW); i++)
            rom[i] = 8'($urandom);
        rst_n     = 1'b0;
        cen       = 1'b1;
        wr        = 1'b0;
        wr_op     = OP_START;
        wr_chan   = '0;
        wr_data   = '0;
        host_rd   = 1'b0;
        host_addr = '0;
        rom_data  = '0;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;

        @(negedge clk);
        if ({rom_cs, wr_busy, host_busy, host_valid, sample.valid} !== 5'b0)
            report_mismatch("idle outputs", {rom_cs, wr_busy, host_busy, host_valid,
                            sample.valid}, 0);
        repeat (40) @(negedge clk);                 // Any fetch here is flagged by the monitor.

        foreach (rows[r]) begin
            reg_write(OP_KEYOFF, rows[r].chan, 0);
            reg_write(OP_START, rows[r].chan, rows[r].start);
            reg_write(OP_END, rows[r].chan, rows[r].stop);
            reg_write(OP_KEYON, rows[r].chan, 0);
            host_read(rows[r].haddr);
            repeat (3) host_read(20'($urandom));    // More reads under load.
            if (rows[r].off_after != 0) begin
                repeat (rows[r].off_after) @(posedge clk);
                reg_write(OP_KEYOFF, rows[r].chan, 0);
                repeat (40) @(negedge clk);         // Channel must stay quiet while off.
                reg_write(OP_KEYON, rows[r].chan, 0);
            end
        end

        foreach (rows[r]) begin
            while (m_nib[rows[r].chan] < rows[r].stop * NIB)
                @(negedge clk);                     // Each channel runs up to its end block.
        end
        repeat (60) @(negedge clk);                 // No fetch may follow the end block.
        if (exp_q.size() != 0)
            report_error($sformatf("%0d samples never appeared", exp_q.size()));

        $display("Errors: %0d value mismatches, %0d other failures", err_val, err_other);
        if (err_val + err_other == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Longest playback times the row count, plus room for writes and host reads.
    initial begin
        int span;
        span = 0;
        foreach (rows[r]) begin
            if ((rows[r].stop - rows[r].start) * NIB * 7 > span)
                span = (rows[r].stop - rows[r].start) * NIB * 7;
        end
        #((NROWS * span + 10000) * 100);
        $display("ERROR: watchdog expired before the run finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/adpcm_pkg.sv
src/adpcm_regs.sv
adpcm_cnt/adpcm_cnt.sv
src/rom_arbiter.sv
src/adpcm_decode.sv
src/adpcm_top.sv
tests/adpcm_asserts.sv
tests/adpcm_tb.sv

// ==== Bender.yml ====
package:
  name: adpcm_a_fetch

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/adpcm_pkg.sv
      - src/adpcm_regs.sv
      - adpcm_cnt/adpcm_cnt.sv
      - src/rom_arbiter.sv
      - src/adpcm_decode.sv
      - src/adpcm_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/adpcm_asserts.sv
      - tests/adpcm_tb.sv
